// ==== common/c16_kbd_pkg.sv ====
`default_nettype none

package c16_kbd_pkg;

	// Scancode prefix tracking in the decoder
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_EXT,
		ST_BREAK,
		ST_EXT_BREAK
	} kbd_state_e;

	// Key operation applied to the matrix
	typedef enum logic [0:0] {
		OP_PRESS,
		OP_RELEASE
	} key_op_e;

	// C16 keyboard matrix, 8 rows by 8 columns
	localparam int MATRIX_ROWS = 8;
	localparam int MATRIX_COLS = 8;

	// One matrix position for a scancode
	typedef struct packed {
		logic       valid;
		logic [2:0] row;
		logic [2:0] col;
	} key_code_t;

	//////////////////////////////////////////////////
	// Scancode set 2 to C16 matrix
	//////////////////////////////////////////////////
	function automatic key_code_t map_scancode(
		input  logic [7:0] code,
		input  logic       ext,
		output logic       is_ctrl,
		output logic       is_alt,
		output logic       is_del
	);
		key_code_t k;
		k       = '0;
		is_ctrl = 1'b0;
		is_alt  = 1'b0;
		is_del  = 1'b0;
		// Index is {extended, code}
		case ({ext, code})
			9'h01C: k = '{1'b1, 3'd1, 3'd2};	// A
			9'h01B: k = '{1'b1, 3'd1, 3'd5};	// S
			9'h023: k = '{1'b1, 3'd2, 3'd2};	// D
			9'h01D: k = '{1'b1, 3'd1, 3'd1};	// W
			9'h01A: k = '{1'b1, 3'd1, 3'd4};	// Z
			9'h022: k = '{1'b1, 3'd2, 3'd7};	// X
			9'h016: k = '{1'b1, 3'd7, 3'd0};	// 1
			9'h01E: k = '{1'b1, 3'd7, 3'd3};	// 2
			9'h026: k = '{1'b1, 3'd1, 3'd0};	// 3
			9'h025: k = '{1'b1, 3'd1, 3'd3};	// 4
			9'h05A: k = '{1'b1, 3'd0, 3'd1};	// RETURN
			9'h029: k = '{1'b1, 3'd7, 3'd4};	// SPACE
			// Keypad 8, 2, 4, 6 act as cursor keys
			9'h075: k = '{1'b1, 3'd5, 3'd3};	// Up
			9'h072: k = '{1'b1, 3'd5, 3'd0};	// Down
			9'h06B: k = '{1'b1, 3'd6, 3'd0};	// Left
			9'h074: k = '{1'b1, 3'd6, 3'd3};	// Right
			9'h012: k = '{1'b1, 3'd1, 3'd7};	// Left shift
			9'h00D: k = '{1'b1, 3'd7, 3'd5};	// Tab is the Commodore key
			// Reset combination keys, not part of the matrix
			9'h014: is_ctrl = 1'b1;
			9'h011: is_alt  = 1'b1;
			9'h171: is_del  = 1'b1;
			default: k = '0;
		endcase
		return k;
	endfunction

endpackage

`default_nettype wire

// ==== ps2/ps2_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_receiver #(
	parameter int FILTER_LEN = 4
) (
	input  wire        CLK28,
	input  wire        rst,
	input  wire        ps2_clk,
	input  wire        ps2_data,
	output logic [7:0] rx_byte,
	output logic       rx_done
);

	localparam int CNT_W = $clog2(FILTER_LEN + 1);

	//////////////////////////////////////////////////
	// Input synchronizers
	//////////////////////////////////////////////////
	logic [1:0] clk_sync;
	logic [1:0] data_sync;

	always_ff @(posedge CLK28) begin
		clk_sync  <= {clk_sync[0], ps2_clk};
		data_sync <= {data_sync[0], ps2_data};
	end

	//////////////////////////////////////////////////
	// Clock glitch filter
	//////////////////////////////////////////////////
	logic             clk_filt;
	logic [CNT_W-1:0] filt_cnt;
	logic             clk_fall;

	// Level accepted after FILTER_LEN samples that differ from the current one
	assign clk_fall = clk_filt && !clk_sync[1] && (filt_cnt == CNT_W'(FILTER_LEN - 1));

	always_ff @(posedge CLK28) begin
		if (rst) begin
			clk_filt <= 1'b1;
			filt_cnt <= '0;
		end else if (clk_sync[1] == clk_filt) begin
			filt_cnt <= '0;
		end else if (filt_cnt == CNT_W'(FILTER_LEN - 1)) begin
			clk_filt <= clk_sync[1];
			filt_cnt <= '0;
		end else begin
			filt_cnt <= filt_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Frame shifter, LSB first
	//////////////////////////////////////////////////
	logic [10:0] frame;
	logic [10:0] frame_next;
	logic [3:0]  bit_cnt;
	logic        frame_ok;

	assign frame_next = {data_sync[1], frame[10:1]};
	// Start 0, odd parity over data and parity, stop 1
	assign frame_ok = !frame_next[0] && (^frame_next[9:1]) && frame_next[10];

	always_ff @(posedge CLK28) begin
		if (rst) begin
			bit_cnt <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			if (clk_fall) begin
				if (bit_cnt == 4'd10) begin
					bit_cnt <= '0;
					rx_done <= frame_ok;
				end else if (bit_cnt != 4'd0 || !data_sync[1]) begin
					// A high line in the start slot is not a frame start
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK28) begin
		if (clk_fall) begin
			frame <= frame_next;
		end
		if (clk_fall && bit_cnt == 4'd10) begin
			rx_byte <= frame_next[8:1];
		end
	end

endmodule

`default_nettype wire

// ==== keymatrix/scancode_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module scancode_decoder (
	input  wire                   CLK28,
	input  wire                   rst,
	input  wire  [7:0]            rx_byte,
	input  wire                   rx_done,
	output logic                  op_valid,
	output c16_kbd_pkg::key_op_e  op,
	output logic [2:0]            op_row,
	output logic [2:0]            op_col,
	output logic                  sp_ctrl,
	output logic                  sp_alt,
	output logic                  sp_del,
	output logic                  sp_press
);

	import c16_kbd_pkg::*;

	kbd_state_e state;
	key_code_t  kc;
	logic       is_ext;
	logic       is_rel;
	logic       hit_ctrl;
	logic       hit_alt;
	logic       hit_del;
	logic       is_prefix;

	// Prefix flags held by the state
	assign is_ext    = (state == ST_EXT) || (state == ST_EXT_BREAK);
	assign is_rel    = (state == ST_BREAK) || (state == ST_EXT_BREAK);
	assign is_prefix = (rx_byte == 8'hE0) || (rx_byte == 8'hF0);

	always_comb begin
		kc = map_scancode(rx_byte, is_ext, hit_ctrl, hit_alt, hit_del);
	end

	//////////////////////////////////////////////////
	// Prefix FSM and output strobes
	//////////////////////////////////////////////////
	always_ff @(posedge CLK28) begin
		if (rst) begin
			state    <= ST_IDLE;
			op_valid <= 1'b0;
			sp_ctrl  <= 1'b0;
			sp_alt   <= 1'b0;
			sp_del   <= 1'b0;
		end else begin
			op_valid <= 1'b0;
			sp_ctrl  <= 1'b0;
			sp_alt   <= 1'b0;
			sp_del   <= 1'b0;
			if (rx_done) begin
				if (rx_byte == 8'hE0) begin
					state <= is_rel ? ST_EXT_BREAK : ST_EXT;
				end else if (rx_byte == 8'hF0) begin
					state <= is_ext ? ST_EXT_BREAK : ST_BREAK;
				end else begin
					// Code byte ends the sequence, unmapped codes drop out here
					state    <= ST_IDLE;
					op_valid <= kc.valid;
					sp_ctrl  <= hit_ctrl;
					sp_alt   <= hit_alt;
					sp_del   <= hit_del;
				end
			end
		end
	end

	// Operation payload, qualified by the strobes above
	always_ff @(posedge CLK28) begin
		if (rx_done && !is_prefix) begin
			op       <= is_rel ? OP_RELEASE : OP_PRESS;
			op_row   <= kc.row;
			op_col   <= kc.col;
			sp_press <= !is_rel;
		end
	end

endmodule

`default_nettype wire

// ==== keymatrix/key_matrix.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_matrix (
	input  wire                   CLK28,
	input  wire                   rst,
	input  wire                   op_valid,
	input  wire  c16_kbd_pkg::key_op_e op,
	input  wire  [2:0]            op_row,
	input  wire  [2:0]            op_col,
	input  wire                   sp_ctrl,
	input  wire                   sp_alt,
	input  wire                   sp_del,
	input  wire                   sp_press,
	output logic [c16_kbd_pkg::MATRIX_ROWS*c16_kbd_pkg::MATRIX_COLS-1:0] matrix,
	output logic                  keyreset
);

	import c16_kbd_pkg::*;

	localparam int KEYS = MATRIX_ROWS * MATRIX_COLS;

	logic [$clog2(KEYS)-1:0] key_idx;
	logic                    ctrl_held;
	logic                    alt_held;
	logic                    del_held;

	// Row-major bit index
	assign key_idx = {op_row, op_col};

	//////////////////////////////////////////////////
	// Key states
	//////////////////////////////////////////////////
	always_ff @(posedge CLK28) begin
		if (rst) begin
			matrix <= '0;
		end else if (op_valid) begin
			// Set on press, clear on release
			matrix[key_idx] <= (op == OP_PRESS);
		end
	end

	//////////////////////////////////////////////////
	// Ctrl Alt Del tracking
	//////////////////////////////////////////////////
	always_ff @(posedge CLK28) begin
		if (rst) begin
			ctrl_held <= 1'b0;
			alt_held  <= 1'b0;
			del_held  <= 1'b0;
			keyreset  <= 1'b0;
		end else begin
			if (sp_ctrl) begin
				ctrl_held <= sp_press;
			end
			if (sp_alt) begin
				alt_held <= sp_press;
			end
			if (sp_del) begin
				del_held <= sp_press;
			end
			// One cycle behind the flags
			keyreset <= ctrl_held && alt_held && del_held;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/keyport_6529.sv ====
`timescale 1ns/1ps
`default_nettype none

module keyport_6529 #(
	parameter logic [11:0] KEYPORT_BASE = 12'hFD3
) (
	input  wire         CLK28,
	input  wire         rst,
	input  wire  [15:0] addr,
	input  wire  [7:0]  data_in,
	input  wire         rw,
	input  wire         bus_cycle,
	output logic [7:0]  row_sel,
	output logic [7:0]  keyport_data
);

	logic cs;

	// Whole FD3x page mirrors the single port register
	assign cs = bus_cycle && (addr[15:4] == KEYPORT_BASE);

	always_ff @(posedge CLK28) begin
		if (rst) begin
			row_sel      <= 8'hFF;
			keyport_data <= 8'hFF;
		end else begin
			if (cs && !rw) begin
				row_sel <= data_in;
			end
			// Read back of the port outputs, idle bus floats high
			keyport_data <= (cs && rw) ? row_sel : 8'hFF;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/kbus_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module kbus_scan (
	input  wire         CLK28,
	input  wire         rst,
	input  wire  [15:0] addr,
	input  wire  [7:0]  data_in,
	input  wire         rw,
	input  wire         bus_cycle,
	input  wire  [c16_kbd_pkg::MATRIX_ROWS*c16_kbd_pkg::MATRIX_COLS-1:0] matrix,
	input  wire  [7:0]  row_sel,
	input  wire  [4:0]  joy0,
	input  wire  [4:0]  joy1,
	output logic [7:0]  kbus
);

	import c16_kbd_pkg::*;

	localparam logic [15:0] JOY_LATCH_ADDR = 16'hFF08;

	logic       joy0_off;
	logic       joy1_off;
	logic [4:0] joy0_act;
	logic [4:0] joy1_act;
	logic [7:0] key_cols;
	logic [7:0] kbus_next;

	// TED keyboard latch, select bits are active low
	always_ff @(posedge CLK28) begin
		if (rst) begin
			joy0_off <= 1'b1;
			joy1_off <= 1'b1;
		end else if (bus_cycle && !rw && addr == JOY_LATCH_ADDR) begin
			joy0_off <= data_in[2];
			joy1_off <= data_in[1];
		end
	end

	assign joy0_act = joy0_off ? 5'h00 : joy0;
	assign joy1_act = joy1_off ? 5'h00 : joy1;

	//////////////////////////////////////////////////
	// Column scan
	//////////////////////////////////////////////////
	always_comb begin
		key_cols = 8'hFF;
		// Any pressed key in a selected row pulls its column low
		for (int r = 0; r < MATRIX_ROWS; r++) begin
			if (!row_sel[r]) begin
				key_cols = key_cols & ~matrix[r*MATRIX_COLS +: MATRIX_COLS];
			end
		end
		kbus_next      = key_cols;
		// Directions share columns 0 to 3, fire has its own column per stick
		kbus_next[3:0] = key_cols[3:0] & ~(joy0_act[3:0] | joy1_act[3:0]);
		kbus_next[6]   = key_cols[6] & ~joy0_act[4];
		kbus_next[7]   = key_cols[7] & ~joy1_act[4];
	end

	always_ff @(posedge CLK28) begin
		if (rst) begin
			kbus <= 8'hFF;
		end else begin
			kbus <= kbus_next;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/c16_keyboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module c16_keyboard #(
	parameter int          FILTER_LEN   = 4,
	parameter logic [11:0] KEYPORT_BASE = 12'hFD3
) (
	input  wire         CLK28,
	input  wire         rst,
	input  wire         ps2_clk,
	input  wire         ps2_data,
	input  wire  [4:0]  joy0,
	input  wire  [4:0]  joy1,
	input  wire  [15:0] addr,
	input  wire  [7:0]  data_in,
	input  wire         rw,
	input  wire         bus_cycle,
	output logic [7:0]  kbus,
	output logic [7:0]  keyport_data,
	output logic        keyreset
);

	import c16_kbd_pkg::*;

	logic [7:0]                           rx_byte;
	logic                                 rx_done;
	logic                                 op_valid;
	key_op_e                              op;
	logic [2:0]                           op_row;
	logic [2:0]                           op_col;
	logic                                 sp_ctrl;
	logic                                 sp_alt;
	logic                                 sp_del;
	logic                                 sp_press;
	logic [MATRIX_ROWS*MATRIX_COLS-1:0]   matrix;
	logic [7:0]                           row_sel;

	//////////////////////////////////////////////////
	// PS/2 side
	//////////////////////////////////////////////////
	ps2_receiver #(
		.FILTER_LEN(FILTER_LEN)
	) u_ps2_receiver (
		.CLK28   (CLK28),
		.rst     (rst),
		.ps2_clk (ps2_clk),
		.ps2_data(ps2_data),
		.rx_byte (rx_byte),
		.rx_done (rx_done)
	);

	scancode_decoder u_scancode_decoder (
		.CLK28   (CLK28),
		.rst     (rst),
		.rx_byte (rx_byte),
		.rx_done (rx_done),
		.op_valid(op_valid),
		.op      (op),
		.op_row  (op_row),
		.op_col  (op_col),
		.sp_ctrl (sp_ctrl),
		.sp_alt  (sp_alt),
		.sp_del  (sp_del),
		.sp_press(sp_press)
	);

	// Key state, also the source of the Ctrl Alt Del reset
	key_matrix u_key_matrix (
		.CLK28   (CLK28),
		.rst     (rst),
		.op_valid(op_valid),
		.op      (op),
		.op_row  (op_row),
		.op_col  (op_col),
		.sp_ctrl (sp_ctrl),
		.sp_alt  (sp_alt),
		.sp_del  (sp_del),
		.sp_press(sp_press),
		.matrix  (matrix),
		.keyreset(keyreset)
	);

	//////////////////////////////////////////////////
	// CPU bus side
	//////////////////////////////////////////////////
	keyport_6529 #(
		.KEYPORT_BASE(KEYPORT_BASE)
	) u_keyport_6529 (
		.CLK28       (CLK28),
		.rst         (rst),
		.addr        (addr),
		.data_in     (data_in),
		.rw          (rw),
		.bus_cycle   (bus_cycle),
		.row_sel     (row_sel),
		.keyport_data(keyport_data)
	);

	kbus_scan u_kbus_scan (
		.CLK28    (CLK28),
		.rst      (rst),
		.addr     (addr),
		.data_in  (data_in),
		.rw       (rw),
		.bus_cycle(bus_cycle),
		.matrix   (matrix),
		.row_sel  (row_sel),
		.joy0     (joy0),
		.joy1     (joy1),
		.kbus     (kbus)
	);

endmodule

`default_nettype wire

// ==== tests/c16_keyboard_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module c16_keyboard_assert (
	input wire CLK28,
	input wire rst,
	input wire rx_done,
	input wire op_valid,
	input wire keyreset
);

	//////////////////////////////////////////////////
	// Strobe shape between the pipeline stages
	//////////////////////////////////////////////////
	// Byte strobe from the receiver is one cycle wide
	rx_done_pulse: assert property (@(posedge CLK28) disable iff (rst) rx_done |=> !rx_done)
		else $error("rx_done high for two cycles in a row");

	op_valid_pulse: assert property (@(posedge CLK28) disable iff (rst) op_valid |=> !op_valid)
		else $error("op_valid high for two cycles in a row");

	// Decoder answers exactly one cycle after a byte
	op_after_byte: assert property (@(posedge CLK28) disable iff (rst) op_valid |-> $past(rx_done))
		else $error("op_valid without rx_done one cycle before");

	// No reset request right out of reset
	quiet_after_reset: assert property (@(posedge CLK28) $fell(rst) |-> !keyreset ##1 !keyreset)
		else $error("keyreset high within two cycles after reset");

endmodule

bind c16_keyboard c16_keyboard_assert u_c16_keyboard_assert (
	.CLK28   (CLK28),
	.rst     (rst),
	.rx_done (rx_done),
	.op_valid(op_valid),
	.keyreset(keyreset)
);

`default_nettype wire

// ==== tests/tb_c16_keyboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_c16_keyboard;

	import c16_kbd_pkg::*;

	localparam logic [31:0] SEED = 32'h8702eb4e;
	// Frames sent: 54 directed keys, up to 400 random, 6 prefix and parity,
	// up to 60 joystick rounds, 13 for Ctrl Alt Del, with some headroom
	localparam int FRAME_COUNT = 540;
	localparam int CYCLE_LIMIT = FRAME_COUNT * 500 + 5000;
	localparam int SETTLE      = 8;

	logic        CLK28;
	logic        rst;
	logic        ps2_clk;
	logic        ps2_data;
	logic [4:0]  joy0;
	logic [4:0]  joy1;
	logic [15:0] addr;
	logic [7:0]  data_in;
	logic        rw;
	logic        bus_cycle;
	wire  [7:0]  kbus;
	wire  [7:0]  keyport_data;
	wire         keyreset;

	// Reference state of the keyboard subsystem
	logic [63:0] model_keys;
	logic [7:0]  model_rows;
	logic        model_j0_off;
	logic        model_j1_off;
	logic [4:0]  model_joy0;
	logic [4:0]  model_joy1;
	logic        model_ctrl;
	logic        model_alt;
	logic        model_del;

	bit          check_armed;
	int          fail_cnt;
	int unsigned cycle_cnt;

	// Plain set 2 codes of the mapped matrix keys
	logic [7:0] key_codes [18] = '{8'h1C, 8'h1B, 8'h23, 8'h1D, 8'h1A, 8'h22,
		8'h16, 8'h1E, 8'h26, 8'h25, 8'h5A, 8'h29, 8'h75, 8'h72, 8'h6B, 8'h74,
		8'h12, 8'h0D};

	c16_keyboard #(
		.FILTER_LEN  (4),
		.KEYPORT_BASE(12'hFD3)
	) u_c16_keyboard (
		.CLK28       (CLK28),
		.rst         (rst),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.joy0        (joy0),
		.joy1        (joy1),
		.addr        (addr),
		.data_in     (data_in),
		.rw          (rw),
		.bus_cycle   (bus_cycle),
		.kbus        (kbus),
		.keyport_data(keyport_data),
		.keyreset    (keyreset)
	);

	initial begin
		CLK28 = 1'b0;
		forever #2 CLK28 = ~CLK28;
	end

	//////////////////////////////////////////////////
	// Reference model and compare tasks
	//////////////////////////////////////////////////
	function automatic logic [7:0] expected_kbus(
		input logic [63:0] keys,
		input logic [7:0]  rows,
		input logic        j0_off,
		input logic        j1_off,
		input logic [4:0]  j0,
		input logic [4:0]  j1
	);
		logic [7:0] res;
		res = 8'hFF;
		// A pressed key in any selected row pulls its column low
		for (int c = 0; c < 8; c++) begin
			for (int r = 0; r < 8; r++) begin
				if (!rows[r] && keys[r*8+c]) begin
					res[c] = 1'b0;
				end
			end
		end
		// Directions on columns 0 to 3
		for (int d = 0; d < 4; d++) begin
			if ((!j0_off && j0[d]) || (!j1_off && j1[d])) begin
				res[d] = 1'b0;
			end
		end
		// Fire buttons, 6 for stick 0 and 7 for stick 1
		if (!j0_off && j0[4]) begin
			res[6] = 1'b0;
		end
		if (!j1_off && j1[4]) begin
			res[7] = 1'b0;
		end
		return res;
	endfunction

	task automatic stop_with_failure(input string line);
		fail_cnt++;
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("mismatch at %0t: %s is %02h, expected %02h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("mismatch at %0t: %s is %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	// Compare on the falling edge, outputs are stable there
	always @(negedge CLK28) begin
		if (check_armed) begin
			check_byte(kbus, expected_kbus(model_keys, model_rows, model_j0_off,
				model_j1_off, model_joy0, model_joy1), "kbus");
			check_bit(keyreset, model_ctrl && model_alt && model_del, "keyreset");
			check_byte(keyport_data, 8'hFF, "idle keyport_data");
		end
	end

	task automatic settle_and_check();
		repeat (SETTLE) @(posedge CLK28);
		check_armed = 1'b1;
		repeat (2) @(posedge CLK28);
		check_armed = 1'b0;
	endtask

	task automatic expect_kbus(input logic [7:0] exp, input string what);
		@(negedge CLK28);
		check_byte(kbus, exp, what);
	endtask

	task automatic expect_keyreset(input logic exp, input string what);
		@(negedge CLK28);
		check_bit(keyreset, exp, what);
	endtask

	//////////////////////////////////////////////////
	// PS/2 and bus stimulus
	//////////////////////////////////////////////////
	task automatic send_frame(input logic [7:0] code, input logic bad_parity);
		logic [10:0] frame_bits;
		logic        par;
		// Odd parity over data and parity bit
		par = ~^code;
		if (bad_parity) begin
			par = ~par;
		end
		frame_bits = {1'b1, par, code, 1'b0};
		// 40 cycle bit period, device changes data while the clock is high
		for (int i = 0; i < 11; i++) begin
			@(posedge CLK28);
			ps2_data <= frame_bits[i];
			repeat (19) @(posedge CLK28);
			ps2_clk <= 1'b0;
			repeat (20) @(posedge CLK28);
			ps2_clk <= 1'b1;
		end
		@(posedge CLK28);
		ps2_data <= 1'b1;
	endtask

	task automatic apply_model(input logic [7:0] code, input logic ext, input logic pressed);
		key_code_t kc;
		logic      is_c;
		logic      is_a;
		logic      is_d;
		kc = map_scancode(code, ext, is_c, is_a, is_d);
		if (kc.valid) begin
			model_keys[{kc.row, kc.col}] = pressed;
		end
		if (is_c) begin
			model_ctrl = pressed;
		end
		if (is_a) begin
			model_alt = pressed;
		end
		if (is_d) begin
			model_del = pressed;
		end
	endtask

	task automatic press_key(input logic [7:0] code, input logic ext);
		if (ext) begin
			send_frame(8'hE0, 1'b0);
		end
		send_frame(code, 1'b0);
		apply_model(code, ext, 1'b1);
	endtask

	// Break sequence is F0 code, or E0 F0 code for extended keys
	task automatic release_key(input logic [7:0] code, input logic ext);
		if (ext) begin
			send_frame(8'hE0, 1'b0);
		end
		send_frame(8'hF0, 1'b0);
		send_frame(code, 1'b0);
		apply_model(code, ext, 1'b0);
	endtask

	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge CLK28);
		addr      <= a;
		data_in   <= d;
		rw        <= 1'b0;
		bus_cycle <= 1'b1;
		@(posedge CLK28);
		bus_cycle <= 1'b0;
		rw        <= 1'b1;
		if (a[15:4] == 12'hFD3) begin
			model_rows = d;
		end
		// TED latch, joystick select active low
		if (a == 16'hFF08) begin
			model_j0_off = d[2];
			model_j1_off = d[1];
		end
	endtask

	task automatic bus_read_check(input logic [15:0] a, input logic [7:0] exp);
		@(posedge CLK28);
		addr      <= a;
		rw        <= 1'b1;
		bus_cycle <= 1'b1;
		@(posedge CLK28);
		bus_cycle <= 1'b0;
		@(negedge CLK28);
		check_byte(keyport_data, exp, "keyport_data read");
	endtask

	task automatic set_joy(input logic [4:0] j0, input logic [4:0] j1);
		@(posedge CLK28);
		joy0       <= j0;
		joy1       <= j1;
		model_joy0 = j0;
		model_joy1 = j1;
	endtask

	task automatic random_key_event();
		int idx;
		idx = $urandom_range(0, 17);
		if ($urandom_range(0, 1) == 0) begin
			press_key(key_codes[idx], 1'b0);
		end else begin
			release_key(key_codes[idx], 1'b0);
		end
	endtask

	//////////////////////////////////////////////////
	// Run limit
	//////////////////////////////////////////////////
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge CLK28);
			cycle_cnt++;
		end
		stop_with_failure($sformatf("Timeout after %0d cycles, the tests did not finish",
			cycle_cnt));
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial begin
		key_code_t  kc;
		logic       c_f;
		logic       a_f;
		logic       d_f;
		logic [7:0] rnd;
		void'($urandom(SEED));
		fail_cnt     = 0;
		check_armed  = 1'b0;
		model_keys   = '0;
		model_rows   = 8'hFF;
		model_j0_off = 1'b1;
		model_j1_off = 1'b1;
		model_joy0   = '0;
		model_joy1   = '0;
		model_ctrl   = 1'b0;
		model_alt    = 1'b0;
		model_del    = 1'b0;
		rst       <= 1'b1;
		ps2_clk   <= 1'b1;
		ps2_data  <= 1'b1;
		joy0      <= '0;
		joy1      <= '0;
		addr      <= '0;
		data_in   <= '0;
		rw        <= 1'b1;
		bus_cycle <= 1'b0;
		repeat (3) @(posedge CLK28);
		rst <= 1'b0;

		// Idle state after reset and port read back
		settle_and_check();
		expect_kbus(8'hFF, "kbus after reset");
		check_byte(keyport_data, 8'hFF, "keyport_data after reset");
		rnd = 8'($urandom);
		bus_write(16'hFD30, rnd);
		bus_read_check(16'hFD30, rnd);

		// Each mapped key alone, own row selected, then only other rows
		foreach (key_codes[i]) begin
			kc = map_scancode(key_codes[i], 1'b0, c_f, a_f, d_f);
			bus_write(16'hFD30, ~(8'h01 << kc.row));
			press_key(key_codes[i], 1'b0);
			settle_and_check();
			expect_kbus(~(8'h01 << kc.col), "single key column");
			bus_write(16'hFD30, 8'h01 << kc.row);
			settle_and_check();
			expect_kbus(8'hFF, "key in unselected row");
			// Own row selected again so the release shows on kbus
			bus_write(16'hFD30, ~(8'h01 << kc.row));
			release_key(key_codes[i], 1'b0);
			settle_and_check();
			expect_kbus(8'hFF, "key after release");
		end

		// Random presses and releases with random row selects
		for (int n = 0; n < 200; n++) begin
			bus_write(16'hFD30 | 16'($urandom_range(0, 15)), 8'($urandom));
			random_key_event();
			settle_and_check();
		end

		// Extended code without a mapping and a bad parity frame
		bus_write(16'hFD30, 8'h00);
		release_key(8'h1C, 1'b0);
		settle_and_check();
		press_key(8'h1C, 1'b1);
		settle_and_check();
		send_frame(8'h1C, 1'b1);
		settle_and_check();
		// Receiver still decodes after a dropped frame
		press_key(8'h1C, 1'b0);
		settle_and_check();

		// Joysticks alone, no rows selected
		bus_write(16'hFD30, 8'hFF);
		bus_write(16'hFF08, 8'hFB);
		set_joy(5'h10, 5'h1F);
		settle_and_check();
		expect_kbus(8'hBF, "joystick 0 fire");
		bus_write(16'hFF08, 8'hF9);
		settle_and_check();
		expect_kbus(8'h30, "both joysticks");

		// Joysticks mixed with keys
		for (int n = 0; n < 30; n++) begin
			bus_write(16'hFF08, 8'($urandom));
			set_joy(5'($urandom), 5'($urandom));
			bus_write(16'hFD30, 8'($urandom));
			random_key_event();
			settle_and_check();
		end
		bus_write(16'hFF08, 8'hFF);
		set_joy(5'h00, 5'h00);

		// Ctrl Alt Del
		press_key(8'h14, 1'b0);
		settle_and_check();
		expect_keyreset(1'b0, "keyreset with Ctrl");
		press_key(8'h11, 1'b0);
		settle_and_check();
		expect_keyreset(1'b0, "keyreset with Ctrl Alt");
		press_key(8'h71, 1'b1);
		settle_and_check();
		expect_keyreset(1'b1, "keyreset with Ctrl Alt Del");
		release_key(8'h11, 1'b0);
		settle_and_check();
		expect_keyreset(1'b0, "keyreset after Alt up");
		press_key(8'h11, 1'b0);
		settle_and_check();
		expect_keyreset(1'b1, "keyreset after Alt down");
		release_key(8'h14, 1'b0);
		settle_and_check();
		expect_keyreset(1'b0, "keyreset after Ctrl up");
		press_key(8'h14, 1'b0);
		settle_and_check();
		expect_keyreset(1'b1, "keyreset after Ctrl down");
		release_key(8'h71, 1'b1);
		settle_and_check();
		expect_keyreset(1'b0, "keyreset after Del up");

		if (fail_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/c16_kbd_pkg.sv
ps2/ps2_receiver.sv
keymatrix/scancode_decoder.sv
keymatrix/key_matrix.sv
rtl/keyport_6529.sv
rtl/kbus_scan.sv
rtl/c16_keyboard.sv
tests/c16_keyboard_assert.sv
tests/tb_c16_keyboard.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the C16 keyboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module tb_c16_keyboard -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulator exited with status $run_status"
	exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0
